// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

top=tb_rv_exec_top
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$top" -f rv_exec_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// File: rv_exec_top.f
+incdir+test
source/rv_exec_pkg.sv
source/inst_decoder.sv
source/gpr_file.sv
source/alu_unit.sv
source/exec_ctrl.sv
source/rv_exec_top.sv
test/tb_rv_exec_top.sv

// File: source/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import rv_exec_pkg::*;
(
    input  wire alu_op_e     op_i,
    input  wire [XLEN-1:0]   a_i,
    input  wire [XLEN-1:0]   b_i,
    input  wire br_cond_e    cond_i,
    output logic [XLEN-1:0]  res_o,
    output logic             cond_true_o
);

    logic [4:0] shamt;
    logic       eq, lt, ltu;

    assign shamt = b_i[4:0];

    // ==========================================================
    // arithmetic, logic and shifts
    always_comb begin
        case (op_i)
            ALU_ADD:    res_o = a_i + b_i;
            ALU_SUB:    res_o = a_i - b_i;
            ALU_SLT:    res_o = {31'b0, lt};
            ALU_SLTU:   res_o = {31'b0, ltu};
            ALU_XOR:    res_o = a_i ^ b_i;
            ALU_OR:     res_o = a_i | b_i;
            ALU_AND:    res_o = a_i & b_i;
            ALU_SLL:    res_o = a_i << shamt;
            ALU_SRL:    res_o = a_i >> shamt;
            ALU_SRA:    res_o = $unsigned($signed(a_i) >>> shamt);
            ALU_PASS_B: res_o = b_i;
            default:    res_o = '0;
        endcase
    end

    // ==========================================================
    // branch compare, independent of op_i
    assign eq  = (a_i == b_i);
    assign lt  = ($signed(a_i) < $signed(b_i));
    assign ltu = (a_i < b_i);

    always_comb begin
        case (cond_i)
            BR_EQ:   cond_true_o = eq;
            BR_NE:   cond_true_o = ~eq;
            BR_LT:   cond_true_o = lt;
            BR_GE:   cond_true_o = ~lt;
            BR_LTU:  cond_true_o = ltu;
            BR_GEU:  cond_true_o = ~ltu;
            default: cond_true_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl
    import rv_exec_pkg::*;
(
    input  wire                 clk_i,
    input  wire                 arst_n_i,
    input  wire                 wb_cyc_i,
    input  wire                 wb_stb_i,
    input  wire                 wb_we_i,
    input  wire  [ADR_W-1:0]    wb_adr_i,
    input  wire  [XLEN-1:0]     wb_dat_i,
    output logic [XLEN-1:0]     wb_dat_o,
    output logic                wb_ack_o,
    output logic [XLEN-1:0]     inst_o,
    input  wire  decode_t       dec_i,
    output logic [GPR_AW-1:0]   rf_ra_o,
    output logic [GPR_AW-1:0]   rf_rb_o,
    input  wire  [XLEN-1:0]     rf_da_i,
    input  wire  [XLEN-1:0]     rf_db_i,
    output logic                rf_we_o,
    output logic [GPR_AW-1:0]   rf_wa_o,
    output logic [XLEN-1:0]     rf_wd_o,
    output alu_op_e             alu_op_o,
    output logic [XLEN-1:0]     alu_a_o,
    output logic [XLEN-1:0]     alu_b_o,
    input  wire  [XLEN-1:0]     alu_res_i,
    input  wire                 alu_cond_i
);

    typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_RESP} state_e;

    state_e           state_q;
    logic             stb_low_q;
    logic [ADR_W-1:0] adr_q;
    logic             we_q;
    logic [XLEN-1:0]  dat_q;
    logic [XLEN-1:0]  pc_q;
    status_t          status_q;
    logic             req_take, inst_wr, exec_go, pc_upd;
    logic [XLEN-1:0]  pc_plus4, pc_plus_imm, pc_next, rd_data;

    // a new request needs stb to have dropped since the last one
    assign req_take = (state_q == ST_IDLE) && wb_cyc_i && wb_stb_i && stb_low_q;
    assign inst_wr  = we_q && (adr_q == ADR_INST);
    assign exec_go  = (state_q == ST_EXEC) && inst_wr && !status_q.halted;
    assign pc_upd   = exec_go && (dec_i.cls != CLS_EBREAK) && (dec_i.cls != CLS_ILLEGAL);
    assign wb_ack_o = (state_q == ST_RESP);
    assign inst_o   = dat_q;

    // ==========================================================
    // bus FSM and request latch
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            stb_low_q <= 1'b1;
            adr_q     <= '0;
            we_q      <= 1'b0;
            dat_q     <= '0;
        end else begin
            if (!wb_stb_i) stb_low_q <= 1'b1;
            case (state_q)
                ST_IDLE: begin
                    if (req_take) begin
                        adr_q     <= wb_adr_i;
                        we_q      <= wb_we_i;
                        dat_q     <= wb_dat_i;
                        stb_low_q <= 1'b0;
                        state_q   <= ST_EXEC;
                    end
                end
                ST_EXEC: state_q <= ST_RESP;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ==========================================================
    // operands, writeback and next pc
    assign rf_ra_o  = inst_wr ? dec_i.rs1 : adr_q[GPR_AW-1:0];
    assign rf_rb_o  = dec_i.rs2;
    assign alu_op_o = dec_i.alu_op;
    assign alu_a_o  = dec_i.a_is_pc ? pc_q : rf_da_i;
    assign alu_b_o  = dec_i.b_is_imm ? dec_i.imm : rf_db_i;

    assign pc_plus4    = pc_q + 32'd4;
    assign pc_plus_imm = pc_q + dec_i.imm;

    assign rf_we_o = exec_go && dec_i.wr_reg;
    assign rf_wa_o = dec_i.rd;
    // jumps link the return address
    assign rf_wd_o = ((dec_i.cls == CLS_JAL) || (dec_i.cls == CLS_JALR)) ? pc_plus4 : alu_res_i;

    always_comb begin
        pc_next = pc_plus4;
        case (dec_i.cls)
            CLS_BRANCH: if (alu_cond_i) pc_next = pc_plus_imm;
            CLS_JAL:    pc_next = pc_plus_imm;
            CLS_JALR:   pc_next = {alu_res_i[XLEN-1:1], 1'b0};
            default:    pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q     <= RESET_PC;
            status_q <= '0;
        end else begin
            if (pc_upd) pc_q <= pc_next;
            if (exec_go) begin
                case (dec_i.cls)
                    CLS_BRANCH:  status_q.br_taken <= alu_cond_i;
                    CLS_EBREAK:  status_q.halted   <= 1'b1;
                    CLS_ILLEGAL: status_q.illegal  <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

    // ==========================================================
    // read data with unmapped words as zero
    always_comb begin
        rd_data = '0;
        if (adr_q >= ADR_GPR_BASE)     rd_data = rf_da_i;
        else if (adr_q == ADR_STATUS)  rd_data = status_q;
        else if (adr_q == ADR_PC)      rd_data = pc_q;
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_EXEC) wb_dat_o <= we_q ? '0 : rd_data;
    end

    a_ack_in_cycle: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) wb_ack_o |-> wb_cyc_i
    ) else $error("ack outside of a bus cycle");

    a_ack_single: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) wb_ack_o |=> !wb_ack_o
    ) else $error("ack held for two cycles");

    // EXEC is the one cycle after a request is taken
    a_we_in_exec: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) rf_we_o |-> $past(req_take)
    ) else $error("register write outside EXEC");

endmodule

`default_nettype wire

// File: source/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_file
    import rv_exec_pkg::*;
(
    input  wire                clk_i,
    input  wire                arst_n_i,
    input  wire  [GPR_AW-1:0]  ra_i,
    input  wire  [GPR_AW-1:0]  rb_i,
    output logic [XLEN-1:0]    da_o,
    output logic [XLEN-1:0]    db_o,
    input  wire                we_i,
    input  wire  [GPR_AW-1:0]  wa_i,
    input  wire  [XLEN-1:0]    wd_i
);

    // entry 0 is never written
    logic [NUM_GPR-1:0][XLEN-1:0] regs_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '0;
        end else if (we_i && (wa_i != '0)) begin
            regs_q[wa_i] <= wd_i;
        end
    end

    // x0 reads as zero
    assign da_o = (ra_i == '0) ? '0 : regs_q[ra_i];
    assign db_o = (rb_i == '0) ? '0 : regs_q[rb_i];

    a_x0_write_dropped: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (we_i && (wa_i == '0)) |=> $stable(regs_q)
    ) else $error("register file changed on a write to x0");

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_exec_pkg::*;
(
    input  wire [XLEN-1:0] inst_i,
    output decode_t        dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic is_op, is_op_imm, is_lui, is_auipc;
    logic is_jal, is_jalr, is_branch, is_system;
    logic f7_zero, f7_alt;
    logic op_ok, op_imm_ok, br_ok, jalr_ok, is_ebreak;
    logic alu_kind, uses_rd, uses_rs1, uses_rs2, reg_bad;
    logic [5:0] cls_vec;
    logic [XLEN-1:0] imm_i, imm_b, imm_j, imm_u;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    // ==========================================================
    // major opcode groups
    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_system = (opcode == OPC_SYSTEM);

    assign f7_zero = (funct7 == 7'b000_0000);
    assign f7_alt  = (funct7 == 7'b010_0000);

    // sub and sra are the only alternate R encodings
    assign op_ok = is_op & (f7_zero | (f7_alt & ((funct3 == 3'b000) | (funct3 == 3'b101))));
    // shift immediates still carry a funct7 field
    assign op_imm_ok = is_op_imm & ((funct3 == 3'b001) ? f7_zero :
                                    (funct3 == 3'b101) ? (f7_zero | f7_alt) : 1'b1);
    assign br_ok     = is_branch & (funct3[2:1] != 2'b01);
    assign jalr_ok   = is_jalr & (funct3 == 3'b000);
    assign is_ebreak = is_system & (inst_i[31:7] == {12'h001, 13'h0000});

    // rv32e only has x0..x15
    assign alu_kind = op_ok | op_imm_ok | is_lui | is_auipc;
    assign uses_rd  = alu_kind | is_jal | jalr_ok;
    assign uses_rs1 = op_ok | op_imm_ok | jalr_ok | br_ok;
    assign uses_rs2 = op_ok | br_ok;
    assign reg_bad  = (uses_rd & rd[4]) | (uses_rs1 & rs1[4]) | (uses_rs2 & rs2[4]);

    // one bit per class
    assign cls_vec[0] = alu_kind & ~reg_bad;
    assign cls_vec[1] = br_ok & ~reg_bad;
    assign cls_vec[2] = is_jal & ~reg_bad;
    assign cls_vec[3] = jalr_ok & ~reg_bad;
    assign cls_vec[4] = is_ebreak;
    // illegal is anything unsupported or touching x16 and up
    assign cls_vec[5] = reg_bad | ~(alu_kind | br_ok | is_jal | jalr_ok | is_ebreak);

    // ==========================================================
    // immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'h000};

    always_comb begin
        dec_o = '0;
        if (cls_vec[0])      dec_o.cls = CLS_ALU;
        else if (cls_vec[1]) dec_o.cls = CLS_BRANCH;
        else if (cls_vec[2]) dec_o.cls = CLS_JAL;
        else if (cls_vec[3]) dec_o.cls = CLS_JALR;
        else if (cls_vec[4]) dec_o.cls = CLS_EBREAK;
        else                 dec_o.cls = CLS_ILLEGAL;

        // jumps and auipc reuse the adder
        dec_o.alu_op = ALU_ADD;
        if (is_lui) begin
            dec_o.alu_op = ALU_PASS_B;
        end else if (is_op | is_op_imm) begin
            case (funct3)
                3'b000:  dec_o.alu_op = (is_op & funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  dec_o.alu_op = ALU_SLL;
                3'b010:  dec_o.alu_op = ALU_SLT;
                3'b011:  dec_o.alu_op = ALU_SLTU;
                3'b100:  dec_o.alu_op = ALU_XOR;
                3'b101:  dec_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  dec_o.alu_op = ALU_OR;
                default: dec_o.alu_op = ALU_AND;
            endcase
        end

        dec_o.br_cond = br_cond_e'(funct3);
        dec_o.rd      = rd[GPR_AW-1:0];
        dec_o.rs1     = rs1[GPR_AW-1:0];
        dec_o.rs2     = rs2[GPR_AW-1:0];

        if (is_lui | is_auipc) dec_o.imm = imm_u;
        else if (is_jal)       dec_o.imm = imm_j;
        else if (is_branch)    dec_o.imm = imm_b;
        else                   dec_o.imm = imm_i;

        // branches compare rs1 against rs2 directly
        dec_o.a_is_pc  = is_auipc | is_jal;
        dec_o.b_is_imm = is_op_imm | is_lui | is_auipc | is_jal | is_jalr;
        dec_o.wr_reg   = cls_vec[0] | cls_vec[2] | cls_vec[3];
    end

    always_comb begin
        a_cls_onehot: assert ($onehot(cls_vec))
            else $error("decode class vector not one-hot: %b", cls_vec);
    end

endmodule

`default_nettype wire

// File: source/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    // ==========================================================
    // widths and address map
    localparam int XLEN    = 32;
    localparam int NUM_GPR = 16;
    localparam int GPR_AW  = 4;
    localparam int ADR_W   = 5;

    // word addresses on the bus
    localparam logic [ADR_W-1:0] ADR_INST     = 5'd0;
    localparam logic [ADR_W-1:0] ADR_STATUS   = 5'd1;
    localparam logic [ADR_W-1:0] ADR_PC       = 5'd2;
    // x0..x15 live at 16..31
    localparam logic [ADR_W-1:0] ADR_GPR_BASE = 5'd16;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // ==========================================================
    // encodings
    typedef enum logic [6:0] {
        OPC_OP     = 7'b011_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_SYSTEM = 7'b111_0011,
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    // values match funct3 of the branch
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_EBREAK, CLS_ILLEGAL
    } inst_class_e;

    typedef struct packed {
        inst_class_e       cls;
        alu_op_e           alu_op;
        br_cond_e          br_cond;
        logic [GPR_AW-1:0] rd;
        logic [GPR_AW-1:0] rs1;
        logic [GPR_AW-1:0] rs2;
        logic [XLEN-1:0]   imm;
        logic              a_is_pc;
        logic              b_is_imm;
        logic              wr_reg;
    } decode_t;

    typedef struct packed {
        logic [28:0] zero;
        logic        br_taken;
        logic        illegal;
        logic        halted;
    } status_t;

endpackage

`default_nettype wire

// File: source/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top
    import rv_exec_pkg::*;
(
    input  wire                clk_i,
    input  wire                arst_n_i,
    input  wire                wb_cyc_i,
    input  wire                wb_stb_i,
    input  wire                wb_we_i,
    input  wire  [ADR_W-1:0]   wb_adr_i,
    input  wire  [XLEN-1:0]    wb_dat_i,
    output logic [XLEN-1:0]    wb_dat_o,
    output logic               wb_ack_o
);

    logic [XLEN-1:0]   inst;
    decode_t           dec;
    logic [GPR_AW-1:0] rf_ra, rf_rb, rf_wa;
    logic [XLEN-1:0]   rf_da, rf_db, rf_wd;
    logic              rf_we;
    alu_op_e           alu_op;
    logic [XLEN-1:0]   alu_a, alu_b, alu_res;
    logic              alu_cond;

    exec_ctrl u_ctrl (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .inst_o     (inst),
        .dec_i      (dec),
        .rf_ra_o    (rf_ra),
        .rf_rb_o    (rf_rb),
        .rf_da_i    (rf_da),
        .rf_db_i    (rf_db),
        .rf_we_o    (rf_we),
        .rf_wa_o    (rf_wa),
        .rf_wd_o    (rf_wd),
        .alu_op_o   (alu_op),
        .alu_a_o    (alu_a),
        .alu_b_o    (alu_b),
        .alu_res_i  (alu_res),
        .alu_cond_i (alu_cond)
    );

    inst_decoder u_dec (
        .inst_i (inst),
        .dec_o  (dec)
    );

    gpr_file u_gpr (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ra_i     (rf_ra),
        .rb_i     (rf_rb),
        .da_o     (rf_da),
        .db_o     (rf_db),
        .we_i     (rf_we),
        .wa_i     (rf_wa),
        .wd_i     (rf_wd)
    );

    // branch condition comes straight from the decode
    alu_unit u_alu (
        .op_i        (alu_op),
        .a_i         (alu_a),
        .b_i         (alu_b),
        .cond_i      (dec.br_cond),
        .res_o       (alu_res),
        .cond_true_o (alu_cond)
    );

endmodule

`default_nettype wire

// File: test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ==========================================================
// architectural state of the model
logic [31:0] ref_regs [16];
logic [31:0] ref_pc;
logic        ref_halted;
logic        ref_illegal;
logic        ref_taken;

function automatic void ref_reset();
    for (int i = 0; i < 16; i++) begin
        ref_regs[i] = 32'h0;
    end
    ref_pc      = 32'h0;
    ref_halted  = 1'b0;
    ref_illegal = 1'b0;
    ref_taken   = 1'b0;
endfunction

// rv32 integer semantics, funct3 picks the operation
function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
        3'd0: return alt ? (a - b) : (a + b);
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return sa >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        3'd7: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// applies one instruction word to the model state
function automatic void ref_exec(input logic [31:0] inst);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        ok;
    logic        wr;
    logic        is_br;
    logic        taken;
    if (ref_halted) return;
    opc   = inst[6:0];
    rd    = inst[11:7];
    f3    = inst[14:12];
    rs1   = inst[19:15];
    rs2   = inst[24:20];
    f7    = inst[31:25];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_u = {inst[31:12], 12'h000};
    a       = ref_regs[rs1[3:0]];
    b       = ref_regs[rs2[3:0]];
    ok      = 1'b1;
    wr      = 1'b1;
    is_br   = 1'b0;
    taken   = 1'b0;
    res     = 32'h0;
    next_pc = ref_pc + 32'd4;
    case (opc)
        OPC_OP: begin
            ok  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            ok  = ok && !rs1[4] && !rs2[4];
            res = alu_model(f3, f7[5], a, b);
        end
        OPC_OP_IMM: begin
            if (f3 == 3'd1) ok = (f7 == 7'h00);
            if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
            ok  = ok && !rs1[4];
            res = alu_model(f3, (f3 == 3'd5) && f7[5], a, imm_i);
        end
        OPC_LUI:   res = imm_u;
        OPC_AUIPC: res = ref_pc + imm_u;
        OPC_JAL: begin
            res     = ref_pc + 32'd4;
            next_pc = ref_pc + imm_j;
        end
        OPC_JALR: begin
            ok      = (f3 == 3'd0) && !rs1[4];
            res     = ref_pc + 32'd4;
            next_pc = (a + imm_i) & ~32'd1;
        end
        OPC_BRANCH: begin
            ok    = (f3 != 3'd2) && (f3 != 3'd3) && !rs1[4] && !rs2[4];
            wr    = 1'b0;
            is_br = 1'b1;
            taken = branch_model(f3, a, b);
            if (taken) next_pc = ref_pc + imm_b;
        end
        OPC_SYSTEM: begin
            // ebreak halts and leaves the pc alone
            if (inst == 32'h0010_0073) begin
                ref_halted = 1'b1;
                return;
            end
            ok = 1'b0;
        end
        default: ok = 1'b0;
    endcase
    if (wr && rd[4]) ok = 1'b0;
    if (!ok) begin
        ref_illegal = 1'b1;
        return;
    end
    if (wr && (rd != 5'd0)) ref_regs[rd[3:0]] = res;
    if (is_br) ref_taken = taken;
    ref_pc = next_pc;
endfunction

// ==========================================================
// instruction encoders
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

`endif

// File: test/tb_rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_top
    import rv_exec_pkg::*;
();

    logic        clk = 1'b0;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;

    int          errors = 0;
    int          checks = 0;
    int          timeouts = 0;
    logic [31:0] rng_state = 32'd25;

    `include "tb_ref_model.svh"

    always #5 clk = ~clk;

    rv_exec_top dut0 (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_wdata),
        .wb_dat_o (wb_rdata),
        .wb_ack_o (wb_ack)
    );

    // ==========================================================
    // helpers
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // register index from 1 to 15
    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = next_rand() % 32'd15;
        return r[4:0] + 5'd1;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        ref_reset();
    endtask

    // one classic cycle, edges counts clocks from the request to the ack
    task automatic bus_cycle(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output int edges);
        logic got;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= wdata;
        got   = 1'b0;
        edges = 0;
        rdata = 32'h0;
        // give up after 20 cycles
        while (!got && (edges < 20)) begin
            @(posedge clk);
            edges++;
            if (wb_ack) begin
                got   = 1'b1;
                rdata = wb_rdata;
            end
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!got) begin
            timeouts++;
            $display("timeout: no ack within 20 cycles for address %0d", adr);
        end
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        int          edges;
        bus_cycle(1'b1, adr, data, ignored, edges);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
        int edges;
        bus_cycle(1'b0, adr, 32'h0, data, edges);
    endtask

    task automatic exec_inst(input logic [31:0] inst);
        wb_write(ADR_INST, inst);
        ref_exec(inst);
    endtask

    // lui then addi, upper part rounded for the sign of the low part
    task automatic load_reg(input logic [4:0] idx, input logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + {19'h0, value[11]};
        exec_inst(u_word(upper, idx, OPC_LUI));
        exec_inst(i_word(value[11:0], idx, 3'd0, idx, OPC_OP_IMM));
    endtask

    task automatic check_reg(input string name, input logic [3:0] idx);
        logic [31:0] value;
        wb_read(ADR_GPR_BASE + {1'b0, idx}, value);
        check(name, ref_regs[idx], value);
    endtask

    task automatic check_all_regs(input string name);
        for (int i = 0; i < 16; i++) begin
            check_reg($sformatf("%s x%0d", name, i), 4'(i));
        end
    endtask

    task automatic check_pc(input string name);
        logic [31:0] value;
        wb_read(ADR_PC, value);
        check(name, ref_pc, value);
    endtask

    // halted in bit 0, illegal in bit 1, branch taken in bit 2
    task automatic check_status(input string name);
        logic [31:0] value;
        wb_read(ADR_STATUS, value);
        check(name, {29'h0, ref_taken, ref_illegal, ref_halted}, value);
    endtask

    // ==========================================================
    // test sequence
    initial begin
        logic [31:0] rdata;
        logic [31:0] inst;
        logic [31:0] rnd;
        logic [31:0] va;
        logic [31:0] vb;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [31:0] bad_words [6];
        int          edges;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 5'd0;
        wb_wdata = 32'h0;
        arst_n   = 1'b0;
        ref_reset();
        apply_reset();

        // reset state and first-access latency
        check("reset ack", 32'h0, {31'h0, wb_ack});
        bus_cycle(1'b0, ADR_PC, 32'h0, rdata, edges);
        check("reset ack latency", 32'd2, 32'(edges - 1));
        check("reset pc", ref_pc, rdata);
        check_status("reset status");
        check_all_regs("reset");

        // random alu ops, rd of zero now and then
        for (int n = 0; n < 200; n++) begin
            rs1 = rand_reg();
            rs2 = rand_reg();
            load_reg(rs1, next_rand());
            load_reg(rs2, next_rand());
            rnd = next_rand();
            rd  = (rnd[3:0] == 4'd0) ? 5'd0 : rand_reg();
            rnd = next_rand();
            f3  = rnd[4:2];
            case (rnd[1:0])
                2'd0: begin
                    f7   = (((f3 == 3'd0) || (f3 == 3'd5)) && rnd[5]) ? 7'h20 : 7'h00;
                    inst = r_word(f7, rs2, rs1, f3, rd, OPC_OP);
                end
                2'd1: begin
                    imm12 = rnd[17:6];
                    if (f3 == 3'd1) imm12[11:5] = 7'h00;
                    if (f3 == 3'd5) imm12[11:5] = rnd[5] ? 7'h20 : 7'h00;
                    inst = i_word(imm12, rs1, f3, rd, OPC_OP_IMM);
                end
                2'd2:    inst = u_word(rnd[31:12], rd, OPC_LUI);
                default: inst = u_word(rnd[31:12], rd, OPC_AUIPC);
            endcase
            exec_inst(inst);
            check_reg($sformatf("alu %0d rd", n), rd[3:0]);
            check_pc($sformatf("alu %0d pc", n));
        end
        check_status("alu status");

        // branches, equal, sign-split and unsigned-large operands
        for (int c = 0; c < 8; c++) begin
            if ((c == 2) || (c == 3)) continue;
            for (int n = 0; n < 8; n++) begin
                rs1 = rand_reg();
                rs2 = rand_reg();
                if (rs2 == rs1) rs2 = (rs1 == 5'd15) ? 5'd1 : rs1 + 5'd1;
                va = next_rand();
                vb = next_rand();
                case (n % 4)
                    0: vb = va;
                    1: begin
                        va[31] = 1'b1;
                        vb[31] = 1'b0;
                    end
                    2: begin
                        va[31] = 1'b1;
                        vb[31] = 1'b1;
                    end
                    default: ;
                endcase
                load_reg(rs1, va);
                load_reg(rs2, vb);
                rnd = next_rand();
                exec_inst(b_word({rnd[11:0], 1'b0}, rs2, rs1, 3'(c)));
                check_pc($sformatf("branch f3=%0d %0d pc", c, n));
                check_status($sformatf("branch f3=%0d %0d status", c, n));
            end
        end

        // jal and jalr
        for (int n = 0; n < 10; n++) begin
            rd  = rand_reg();
            rnd = next_rand();
            exec_inst(j_word({rnd[19:0], 1'b0}, rd));
            check_reg($sformatf("jal %0d link", n), rd[3:0]);
            check_pc($sformatf("jal %0d pc", n));
        end
        for (int n = 0; n < 10; n++) begin
            rs1 = rand_reg();
            load_reg(rs1, next_rand());
            rd  = rand_reg();
            rnd = next_rand();
            exec_inst(i_word(rnd[11:0], rs1, 3'd0, rd, OPC_JALR));
            check_reg($sformatf("jalr %0d link", n), rd[3:0]);
            check_pc($sformatf("jalr %0d pc", n));
        end

        // illegal words, each after a fresh reset
        bad_words[0] = i_word(12'h004, 5'd2, 3'd2, 5'd1, OPC_LOAD);
        bad_words[1] = r_word(7'h00, 5'd3, 5'd2, 3'd2, 5'd4, OPC_STORE);
        bad_words[2] = i_word(12'h300, 5'd2, 3'd1, 5'd1, OPC_SYSTEM);
        bad_words[3] = 32'h0000_0073;
        bad_words[4] = 32'h3020_0073;
        bad_words[5] = r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd16, OPC_OP);
        for (int n = 0; n < 6; n++) begin
            apply_reset();
            load_reg(5'd1, next_rand());
            load_reg(5'd2, next_rand());
            load_reg(5'd4, next_rand());
            exec_inst(bad_words[n]);
            check_status($sformatf("illegal %0d status", n));
            check_pc($sformatf("illegal %0d pc", n));
            check_all_regs($sformatf("illegal %0d", n));
        end

        // ebreak, then an addi that must be ignored
        load_reg(5'd3, next_rand());
        exec_inst(32'h0010_0073);
        check_status("halt status");
        check_pc("halt pc");
        exec_inst(i_word(12'h005, 5'd3, 3'd0, 5'd3, OPC_OP_IMM));
        check_reg("halted addi rd", 4'd3);
        check_pc("halted addi pc");
        check_status("halted addi status");

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
